//--- source/lsq_pkg.sv
////////////////////
// shared types and constants for the store-queue operand pipeline
// import with a wildcard in the module or interface header
////////////////////

`default_nettype none

package lsq_pkg;

    ////////////////////
    // data widths

    // register and complete-bus data word
    typedef logic [31:0] word_t;

    // data memory address, also the width of the store immediate
    typedef logic [13:0] daddr_t;

    // physical register tag
    typedef logic [5:0] phys_reg_tag_t;

    // reorder buffer entry
    typedef logic [5:0] rob_index_t;

    // store queue entry
    typedef logic [2:0] sq_index_t;

    ////////////////////
    // operand source select

    // 0..2 pick a complete bus, REG_SEL picks register-file data
    typedef logic [1:0] bus_sel_t;
    localparam bus_sel_t REG_SEL = 2'd3;

    // base address and store data
    localparam int NUM_OPERANDS = 2;

endpackage

`default_nettype wire

//--- source/operand_wakeup_if.sv
////////////////////
// link between the register-read stage and one operand tracker
// the stage loads a task operand, the tracker reports its availability
////////////////////

`timescale 1ns/1ns
`default_nettype none

interface operand_wakeup_if import lsq_pkg::*; ();

    // task load from the register-read stage
    logic          load;
    phys_reg_tag_t load_tag;
    logic          load_ready;

    // task leaves the register-read stage this cycle
    logic          advance;

    // tracker status
    phys_reg_tag_t tag;
    logic          available;
    logic          from_reg;
    bus_sel_t      bus_sel;

    modport stage (
        output load, load_tag, load_ready, advance,
        input  tag, available, from_reg, bus_sel
    );

    modport tracker (
        input  load, load_tag, load_ready, advance,
        output tag, available, from_reg, bus_sel
    );

endinterface

`default_nettype wire

//--- source/operand_wakeup.sv
////////////////////
// wakeup tracking for one store operand
// holds the source tag and ready flag, snoops the complete buses
////////////////////

`timescale 1ns/1ns
`default_nettype none

module operand_wakeup import lsq_pkg::*; #(
    parameter int NUM_COMPLETE_BUSES = 3
) (
    input  logic                  CLK,
    input  logic                  nRST,

    // complete bus tags
    input  logic                  complete_bus_tag_valid [NUM_COMPLETE_BUSES],
    input  phys_reg_tag_t         complete_bus_tag       [NUM_COMPLETE_BUSES],

    operand_wakeup_if.tracker     trk
);

    // held operand state
    phys_reg_tag_t tag_q;
    logic          ready_q;

    // bus match for the held tag
    logic          match_any;
    bus_sel_t      match_sel;

    ////////////////////
    // tag match

    // walk from the top so the lowest matching bus wins
    always_comb begin
        match_any = 1'b0;
        match_sel = REG_SEL;
        for (int b = NUM_COMPLETE_BUSES - 1; b >= 0; b--) begin
            if (complete_bus_tag_valid[b] && (complete_bus_tag[b] == tag_q)) begin
                match_any = 1'b1;
                match_sel = bus_sel_t'(b);
            end
        end
    end

    ////////////////////
    // state

    always_ff @(posedge CLK) begin
        if (trk.load) begin
            tag_q <= trk.load_tag;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ready_q <= 1'b0;
        end else if (trk.load) begin
            ready_q <= trk.load_ready;
        end else if (match_any && !trk.advance) begin
            // value lands in the register file, read it from there later
            ready_q <= 1'b1;
        end
    end

    // status back to the stage
    assign trk.tag       = tag_q;
    assign trk.available = ready_q | match_any;
    assign trk.from_reg  = ready_q;
    assign trk.bus_sel   = ready_q ? REG_SEL : match_sel;

endmodule

`default_nettype wire

//--- source/sq_reg_read_stage.sv
////////////////////
// register-read stage of the store operand pipeline
// latches a dispatched store, waits for both operands, requests the read
////////////////////

`timescale 1ns/1ns
`default_nettype none

module sq_reg_read_stage import lsq_pkg::*; (
    input  logic               CLK,
    input  logic               nRST,

    // dispatch
    input  logic               task_valid,
    input  phys_reg_tag_t      src_tag_0,
    input  phys_reg_tag_t      src_tag_1,
    input  logic               src_ready_0,
    input  logic               src_ready_1,
    input  daddr_t             imm,
    input  sq_index_t          sq_index,
    input  rob_index_t         rob_index,
    output logic               busy,

    // kill bus
    input  logic               kill_valid,
    input  rob_index_t         kill_rob_index,

    // register file
    input  logic               reg_read_serviced,
    output logic               reg_read_req_valid,

    // operand trackers
    operand_wakeup_if.stage    opnd [NUM_OPERANDS],

    // to the address-calculation stage
    output logic               adv,
    output daddr_t             imm_q,
    output sq_index_t          sq_index_q
);

    logic                     valid_q;
    rob_index_t               rob_index_q;

    // task operands as arrays
    phys_reg_tag_t            task_tag [NUM_OPERANDS];
    logic [NUM_OPERANDS-1:0]  task_ready;

    // tracker status
    logic [NUM_OPERANDS-1:0]  avail_vec;
    logic [NUM_OPERANDS-1:0]  from_reg_vec;

    logic                     kill;
    logic                     all_avail;
    logic                     need_read;

    assign task_tag[0]   = src_tag_0;
    assign task_tag[1]   = src_tag_1;
    assign task_ready[0] = src_ready_0;
    assign task_ready[1] = src_ready_1;

    ////////////////////
    // trackers

    for (genvar i = 0; i < NUM_OPERANDS; i++) begin : g_opnd
        assign opnd[i].load       = task_valid;
        assign opnd[i].load_tag   = task_tag[i];
        assign opnd[i].load_ready = task_ready[i];
        assign opnd[i].advance    = adv;
        assign avail_vec[i]       = opnd[i].available;
        assign from_reg_vec[i]    = opnd[i].from_reg;
    end

    ////////////////////
    // advance decision

    assign kill      = valid_q & kill_valid & (rob_index_q == kill_rob_index);
    assign all_avail = &avail_vec;
    // any operand still sitting in the register file
    assign need_read = |from_reg_vec;

    // request held until serviced
    assign reg_read_req_valid = valid_q & ~kill & all_avail & need_read;

    // forwarded-only tasks go at once
    assign adv  = valid_q & ~kill & all_avail & (~need_read | reg_read_serviced);
    assign busy = valid_q & ~adv & ~kill;

    ////////////////////
    // task latch

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= 1'b0;
        end else if (task_valid) begin
            valid_q <= 1'b1;
        end else if (adv || kill) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (task_valid) begin
            imm_q       <= imm;
            sq_index_q  <= sq_index;
            rob_index_q <= rob_index;
        end
    end

endmodule

`default_nettype wire

//--- source/sq_addr_calc_stage.sv
////////////////////
// address-calculation stage of the store operand pipeline
// picks each operand from register or bus data, adds the immediate
////////////////////

`timescale 1ns/1ns
`default_nettype none

module sq_addr_calc_stage import lsq_pkg::*; #(
    parameter int NUM_COMPLETE_BUSES = 3
) (
    input  logic        CLK,
    input  logic        nRST,

    // from the register-read stage
    input  logic        adv,
    input  word_t       reg_read_data_0,
    input  word_t       reg_read_data_1,
    input  bus_sel_t    bus_sel_0,
    input  bus_sel_t    bus_sel_1,
    input  daddr_t      imm_q,
    input  sq_index_t   sq_index_q,

    // complete bus data, one cycle behind its tag
    input  word_t       complete_bus_data [NUM_COMPLETE_BUSES],

    // store write
    output logic        write_valid,
    output daddr_t      write_addr,
    output word_t       write_data,
    output sq_index_t   write_sq_index
);

    // latch stage
    logic       calc_valid_q;
    word_t      reg_data_q [NUM_OPERANDS];
    bus_sel_t   sel_q      [NUM_OPERANDS];
    daddr_t     calc_imm_q;
    sq_index_t  calc_index_q;

    // forwarded operands
    word_t      fwd [NUM_OPERANDS];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            calc_valid_q <= 1'b0;
        end else begin
            calc_valid_q <= adv;
        end
    end

    always_ff @(posedge CLK) begin
        if (adv) begin
            reg_data_q[0] <= reg_read_data_0;
            reg_data_q[1] <= reg_read_data_1;
            sel_q[0]      <= bus_sel_0;
            sel_q[1]      <= bus_sel_1;
            calc_imm_q    <= imm_q;
            calc_index_q  <= sq_index_q;
        end
    end

    ////////////////////
    // forwarding muxes

    // each operand follows its own select
    always_comb begin
        for (int i = 0; i < NUM_OPERANDS; i++) begin
            fwd[i] = reg_data_q[i];
            for (int b = 0; b < NUM_COMPLETE_BUSES; b++) begin
                if (sel_q[i] == bus_sel_t'(b)) begin
                    fwd[i] = complete_bus_data[b];
                end
            end
        end
    end

    ////////////////////
    // output register

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            write_valid <= 1'b0;
        end else begin
            write_valid <= calc_valid_q;
        end
    end

    // base is the low address bits, sum wraps
    always_ff @(posedge CLK) begin
        if (calc_valid_q) begin
            write_addr     <= daddr_t'(fwd[0]) + calc_imm_q;
            write_data     <= fwd[1];
            write_sq_index <= calc_index_q;
        end
    end

endmodule

`default_nettype wire

//--- source/sq_operand_pipeline.sv
////////////////////
// store-queue operand pipeline top level
// dispatch in, register-file read out, store address and data out
////////////////////

`timescale 1ns/1ns
`default_nettype none

module sq_operand_pipeline import lsq_pkg::*; #(
    parameter int NUM_COMPLETE_BUSES = 3
) (
    input  logic          CLK,
    input  logic          nRST,

    // dispatch
    input  logic          task_valid,
    input  phys_reg_tag_t src_tag_0,
    input  phys_reg_tag_t src_tag_1,
    input  logic          src_ready_0,
    input  logic          src_ready_1,
    input  daddr_t        imm,
    input  sq_index_t     sq_index,
    input  rob_index_t    rob_index,
    output logic          busy,

    // register file
    output logic          reg_read_req_valid,
    output phys_reg_tag_t reg_read_req_tag_0,
    output phys_reg_tag_t reg_read_req_tag_1,
    input  logic          reg_read_serviced,
    input  word_t         reg_read_data_0,
    input  word_t         reg_read_data_1,

    // complete buses
    input  logic          complete_bus_tag_valid [NUM_COMPLETE_BUSES],
    input  phys_reg_tag_t complete_bus_tag       [NUM_COMPLETE_BUSES],
    input  word_t         complete_bus_data      [NUM_COMPLETE_BUSES],

    // kill bus
    input  logic          kill_valid,
    input  rob_index_t    kill_rob_index,

    // store write
    output logic          write_valid,
    output daddr_t        write_addr,
    output word_t         write_data,
    output sq_index_t     write_sq_index
);

    operand_wakeup_if opnd_if [NUM_OPERANDS] ();

    logic      adv;
    daddr_t    imm_q;
    sq_index_t sq_index_q;

    sq_reg_read_stage u_sq_reg_read_stage (
        .CLK, .nRST,
        .task_valid, .src_tag_0, .src_tag_1, .src_ready_0, .src_ready_1,
        .imm, .sq_index, .rob_index, .busy,
        .kill_valid, .kill_rob_index,
        .reg_read_serviced, .reg_read_req_valid,
        .opnd (opnd_if),
        .adv, .imm_q, .sq_index_q
    );

    // one tracker per operand
    for (genvar i = 0; i < NUM_OPERANDS; i++) begin : g_wakeup
        operand_wakeup #(.NUM_COMPLETE_BUSES(NUM_COMPLETE_BUSES)) u_operand_wakeup (
            .CLK, .nRST,
            .complete_bus_tag_valid, .complete_bus_tag,
            .trk (opnd_if[i].tracker)
        );
    end

    // read tags straight from the trackers
    assign reg_read_req_tag_0 = opnd_if[0].tag;
    assign reg_read_req_tag_1 = opnd_if[1].tag;

    sq_addr_calc_stage #(.NUM_COMPLETE_BUSES(NUM_COMPLETE_BUSES)) u_sq_addr_calc_stage (
        .CLK, .nRST,
        .adv, .reg_read_data_0, .reg_read_data_1,
        .bus_sel_0 (opnd_if[0].bus_sel),
        .bus_sel_1 (opnd_if[1].bus_sel),
        .imm_q, .sq_index_q, .complete_bus_data,
        .write_valid, .write_addr, .write_data, .write_sq_index
    );

endmodule

`default_nettype wire

//--- tb/sq_operand_properties.sv
////////////////////
// protocol checks for the store-queue operand pipeline
// bound into the top level from the testbench
////////////////////

`timescale 1ns/1ns
`default_nettype none

module sq_operand_properties (
    input  logic CLK,
    input  logic nRST,
    input  logic task_valid,
    input  logic busy,
    input  logic adv,
    input  logic reg_read_req_valid,
    input  logic write_valid
);

    // failed assertion count that the testbench reads at the end
    int   fail_count = 0;

    // low until the first edge after reset release
    logic out_of_reset_q;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            out_of_reset_q <= 1'b0;
        end else begin
            out_of_reset_q <= 1'b1;
        end
    end

    // dispatcher must hold off while the stage is busy
    a_no_task_while_busy: assert property (
        @(posedge CLK) disable iff (!nRST) !(task_valid && busy)
    ) else begin
        $error("task_valid high while busy");
        fail_count++;
    end

    // quiet outputs in the first cycle after reset
    a_quiet_after_reset: assert property (
        @(posedge CLK) (nRST && !out_of_reset_q) |-> (!write_valid && !reg_read_req_valid)
    ) else begin
        $error("write_valid or reg_read_req_valid high right after reset");
        fail_count++;
    end

    // a stalled read stays requested until the task leaves or is killed
    a_req_held: assert property (
        @(posedge CLK) disable iff (!nRST)
        (reg_read_req_valid && !adv) |=> (reg_read_req_valid || !busy)
    ) else begin
        $error("stalled register read dropped while the stage is still busy");
        fail_count++;
    end

endmodule

`default_nettype wire

//--- tb/tb_sq_operand_pipeline.sv
////////////////////
// testbench for the store-queue operand pipeline
// plays one store task per line of tb/sq_testdata.txt, checks the writes
////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_sq_operand_pipeline import lsq_pkg::*; ();

    localparam int NUM_BUSES = 3;
    localparam int HALF      = 4;
    // cycles watched for a stray write after a kill
    localparam int QUIET     = 6;
    // marks a missing wake, kill or service in the testdata
    localparam int NONE      = 'hff;
    // bus and register data outside their valid cycle
    localparam word_t POISON = 32'hdead_0bad;

    logic          CLK = 1'b0;
    logic          nRST;

    // dispatch
    logic          task_valid;
    phys_reg_tag_t src_tag_0, src_tag_1;
    logic          src_ready_0, src_ready_1;
    daddr_t        imm;
    sq_index_t     sq_index;
    rob_index_t    rob_index;
    logic          busy;

    // register file
    logic          reg_read_req_valid;
    phys_reg_tag_t reg_read_req_tag_0, reg_read_req_tag_1;
    logic          reg_read_serviced;
    word_t         reg_read_data_0, reg_read_data_1;

    // complete and kill buses
    logic          complete_bus_tag_valid [NUM_BUSES];
    phys_reg_tag_t complete_bus_tag       [NUM_BUSES];
    word_t         complete_bus_data      [NUM_BUSES];
    logic          kill_valid;
    rob_index_t    kill_rob_index;

    // store write
    logic          write_valid;
    daddr_t        write_addr;
    word_t         write_data;
    sq_index_t     write_sq_index;

    string         lines [$];
    bit            lines_loaded = 1'b0;

    sq_operand_pipeline #(.NUM_COMPLETE_BUSES(NUM_BUSES)) u_sq_operand_pipeline (.*);

    bind sq_operand_pipeline sq_operand_properties u_props (
        .CLK (CLK), .nRST (nRST), .task_valid (task_valid), .busy (busy), .adv (adv),
        .reg_read_req_valid (reg_read_req_valid), .write_valid (write_valid)
    );

    always #HALF CLK = ~CLK;

    ////////////////////
    // compare tasks

    task automatic stop_on_error();
        $display("Testbench failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_addr(input string name, input daddr_t got, input daddr_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_index(input string name, input sq_index_t got, input sq_index_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_tag(input string name, input phys_reg_tag_t got,
                             input phys_reg_tag_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    ////////////////////
    // stimulus

    // every input idle, data poisoned
    task automatic drive_idle();
        task_valid        = 1'b0;
        src_tag_0         = '0;
        src_tag_1         = '0;
        src_ready_0       = 1'b0;
        src_ready_1       = 1'b0;
        imm               = '0;
        sq_index          = '0;
        rob_index         = '0;
        reg_read_serviced = 1'b0;
        reg_read_data_0   = POISON;
        reg_read_data_1   = POISON;
        kill_valid        = 1'b0;
        kill_rob_index    = '0;
        for (int b = 0; b < NUM_BUSES; b++) begin
            complete_bus_tag_valid[b] = 1'b0;
            complete_bus_tag[b]       = '0;
            complete_bus_data[b]      = POISON;
        end
    endtask

    // one store task, cycle k counts from the acceptance edge
    task automatic run_line(input string line);
        int tag [2];
        int rdy [2];
        int rd [2];
        int wb [2];
        int wd [2];
        int bd [NUM_BUSES];
        int imm_v, sqi_v, rob_v;
        int svc_at, kill_at, rq_exp;
        int exp_addr, exp_data, exp_idx;
        int n, k, rq_seen;
        bit done;

        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    tag[0], tag[1], rdy[0], rdy[1], imm_v, sqi_v, rob_v, rd[0], rd[1],
                    wb[0], wd[0], wb[1], wd[1], svc_at, kill_at, bd[0], bd[1], bd[2],
                    rq_exp, exp_addr, exp_data, exp_idx);
        if (n != 22) begin
            $display("malformed testdata line: %s", line);
            stop_on_error();
        end

        // random idle gap
        repeat ($urandom % 4) @(negedge CLK);
        @(negedge CLK);
        check_bit("busy", busy, 1'b0);
        drive_idle();
        task_valid  = 1'b1;
        src_tag_0   = phys_reg_tag_t'(tag[0]);
        src_tag_1   = phys_reg_tag_t'(tag[1]);
        src_ready_0 = rdy[0][0];
        src_ready_1 = rdy[1][0];
        imm         = daddr_t'(imm_v);
        sq_index    = sq_index_t'(sqi_v);
        rob_index   = rob_index_t'(rob_v);

        k       = 0;
        rq_seen = 0;
        done    = 1'b0;
        while (!done) begin
            @(negedge CLK);
            drive_idle();
            for (int i = 0; i < 2; i++) begin
                // tag first, its data one cycle later
                if (wd[i] == k) begin
                    complete_bus_tag_valid[wb[i]] = 1'b1;
                    complete_bus_tag[wb[i]]       = phys_reg_tag_t'(tag[i]);
                end
                if (wd[i] + 1 == k) begin
                    complete_bus_data[wb[i]] = word_t'(bd[wb[i]]);
                end
            end
            // read data only valid while serviced
            reg_read_serviced = (k >= svc_at);
            if (reg_read_serviced) begin
                reg_read_data_0 = word_t'(rd[0]);
                reg_read_data_1 = word_t'(rd[1]);
            end
            if (k == kill_at) begin
                kill_valid     = 1'b1;
                kill_rob_index = rob_index_t'(rob_v);
            end

            // outputs settle after the new inputs
            #1;
            if (reg_read_req_valid) begin
                rq_seen++;
                check_tag("reg_read_req_tag_0", reg_read_req_tag_0, phys_reg_tag_t'(tag[0]));
                check_tag("reg_read_req_tag_1", reg_read_req_tag_1, phys_reg_tag_t'(tag[1]));
                // stalled read holds the stage
                if (!reg_read_serviced) begin
                    check_bit("busy", busy, 1'b1);
                end
            end
            if (write_valid) begin
                if (kill_at != NONE) begin
                    $display("a killed store task still produced write_valid at %0t ns", $time);
                    stop_on_error();
                end
                check_addr("write_addr", write_addr, daddr_t'(exp_addr));
                check_word("write_data", write_data, word_t'(exp_data));
                check_index("write_sq_index", write_sq_index, sq_index_t'(exp_idx));
                check_count("read request cycles", rq_seen, rq_exp);
                done = 1'b1;
            end else if (kill_at != NONE && k >= kill_at + QUIET) begin
                check_count("read request cycles", rq_seen, rq_exp);
                done = 1'b1;
            end
            k++;
        end
    endtask

    ////////////////////
    // main sequence

    initial begin
        int    fd;
        string line;

        void'($urandom(32'h8bfb));
        nRST = 1'b0;
        drive_idle();

        fd = $fopen("tb/sq_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/sq_testdata.txt");
            stop_on_error();
        end
        // keep task lines, drop comments and blank lines
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) > 0 && line.len() > 1 && line.getc(0) != "#") begin
                lines.push_back(line);
            end
        end
        $fclose(fd);
        lines_loaded = 1'b1;

        repeat (3) @(negedge CLK);
        nRST = 1'b1;

        foreach (lines[i]) begin
            run_line(lines[i]);
        end
        repeat (4) @(negedge CLK);

        if (u_sq_operand_pipeline.u_props.fail_count != 0) begin
            $display("%0d protocol assertions failed", u_sq_operand_pipeline.u_props.fail_count);
            $display("Testbench failed");
            $fatal(1, "protocol assertions failed");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

    // watchdog, 40 cycles per store task
    initial begin
        wait (lines_loaded);
        #(lines.size() * 40 * 2 * HALF);
        $display("watchdog expired before all store tasks completed");
        stop_on_error();
    end

endmodule

`default_nettype wire

//--- tb/sq_testdata.txt
# tag0 tag1 rdy0 rdy1 imm sq rob rdata0 rdata1 wbus0 wdly0 wbus1 wdly1 svc kill
#   bdata0 bdata1 bdata2 req_cycles exp_addr exp_data exp_idx   (hex, ff = none)
05 0a 1 1 0010 1 03 00001234 cafef00d 0 ff 0 ff 00 ff 00000000 00000000 00000000 1 1244 cafef00d 1
11 12 0 0 3fff 2 04 ffffffff ffffffff 0 01 2 01 00 ff 0000abcd 00000000 87654321 0 2bcc 87654321 2
20 21 1 0 0004 3 05 00000100 ffffffff 0 ff 1 02 00 ff 00000000 5a5a5a5a 00000000 1 0104 5a5a5a5a 3
30 31 0 1 0100 4 06 ffffffff 13572468 2 00 0 ff 00 ff 00000000 00000000 00003ff0 1 00f0 13572468 4
01 02 0 0 0020 5 07 00001000 11112222 0 01 1 03 06 ff 00002000 99999999 00000000 4 1020 11112222 5
3a 3b 0 1 0000 6 2a 00000000 00000000 0 ff 0 ff 00 02 00000000 00000000 00000000 0 0000 00000000 6
07 08 1 1 1555 7 2b 0000aaaa deadbeef 0 ff 0 ff 05 ff 00000000 00000000 00000000 6 3fff deadbeef 7
0c 0d 1 1 0001 0 15 00000000 00000000 0 ff 0 ff ff 03 00000000 00000000 00000000 3 0000 00000000 0
1e 1f 0 1 0003 2 16 00000abc 76543210 1 00 0 ff 02 ff 00000000 ffffffff 00000000 3 0abf 76543210 2

//--- files.f
source/lsq_pkg.sv
source/operand_wakeup_if.sv
source/operand_wakeup.sv
source/sq_reg_read_stage.sv
source/sq_addr_calc_stage.sv
source/sq_operand_pipeline.sv
tb/sq_operand_properties.sv
tb/tb_sq_operand_pipeline.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the store-queue operand pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timescale 1ns/1ns -f files.f \
    --top-module tb_sq_operand_pipeline -o sim_tb

# the log decides pass or fail
./obj_dir/sim_tb +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench failed" sim.log; then
    exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
